/* design/apb_cpu_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_cpu_bridge (
	input  logic                          fclk,
	input  logic                          arst_n,
	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  logic [zx_mem_pkg::z_addr_w:0] paddr,
	input  logic [7:0]                    pwdata,
	input  zx_mem_pkg::map_t              map,
	input  zx_mem_pkg::dram_rsp_t         cpu_rsp,
	output logic [7:0]                    prdata,
	output logic                          pready,
	output logic [zx_mem_pkg::z_addr_w-1:0] z_addr,
	output zx_mem_pkg::cfg_wr_t           cfg_wr,
	output zx_mem_pkg::dram_req_t         cpu_req
);
	import zx_mem_pkg::*;

	typedef enum logic [1:0] {st_idle, st_wait, st_done} state_e;

	state_e                 state_q;
	logic                   setup;
	logic                   is_cfg;
	logic                   req_q;
	logic [word_addr_w-1:0] addr_q;
	logic                   rnw_q;
	logic [7:0]             wbyte_q;
	logic [1:0]             bsel_q;
	logic                   cfg_valid_q;
	cfg_reg_e               cfg_sel_q;
	logic [7:0]             cfg_data_q;

	assign setup  = psel && !penable;
	// upper half of the apb space holds the config registers
	assign is_cfg = paddr[z_addr_w];
	assign z_addr = paddr[z_addr_w-1:0];

	assign cfg_wr  = '{valid: cfg_valid_q, sel: cfg_sel_q, data: cfg_data_q};
	assign cpu_req = '{req: req_q, addr: addr_q, rnw: rnw_q,
		wdata: {wbyte_q, wbyte_q}, bsel: bsel_q};

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state_q     <= st_idle;
			pready      <= 1'b0;
			req_q       <= 1'b0;
			cfg_valid_q <= 1'b0;
		end
		else
		begin
			cfg_valid_q <= 1'b0;
			case (state_q)
				st_idle:
					if (setup)
					begin
						if (is_cfg || (pwrite && map.is_rom))
						begin
							// no dram cycle, done in first access cycle
							cfg_valid_q <= is_cfg && pwrite;
							pready      <= 1'b1;
							state_q     <= st_done;
						end
						else
						begin
							req_q   <= 1'b1;
							state_q <= st_wait;
						end
					end
				st_wait:
					if (cpu_rsp.strobe)
					begin
						req_q   <= 1'b0;
						pready  <= 1'b1;
						state_q <= st_done;
					end
				default:
					if (psel && penable)
					begin
						pready  <= 1'b0;
						state_q <= st_idle;
					end
			endcase
		end
	end

	// payload, captured in the setup phase
	always_ff @(posedge fclk)
	begin
		if (state_q == st_idle && setup)
		begin
			addr_q     <= map.addr;
			rnw_q      <= !pwrite;
			wbyte_q    <= pwdata;
			bsel_q     <= z_addr[0] ? 2'b10 : 2'b01;
			cfg_sel_q  <= cfg_reg_e'(paddr[3:0]);
			cfg_data_q <= pwdata;
			prdata     <= 8'hff;
		end
		else if (state_q == st_wait && cpu_rsp.strobe)
			prdata <= z_addr[0] ? cpu_rsp.rdata[15:8] : cpu_rsp.rdata[7:0];
	end

endmodule

`default_nettype wire

/* design/dram_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module dram_arbiter (
	input  logic                     fclk,
	input  logic                     arst_n,
	input  zx_mem_pkg::cycle_phase_e phase,
	input  zx_mem_pkg::dram_req_t    cpu_req,
	input  zx_mem_pkg::dram_req_t    vid_req,
	input  logic [15:0]              rd_data,
	output zx_mem_pkg::dram_req_t    mem_req,
	output zx_mem_pkg::dram_rsp_t    cpu_rsp,
	output zx_mem_pkg::dram_rsp_t    vid_rsp
);
	import zx_mem_pkg::*;

	owner_e owner_q;
	owner_e last_q;
	owner_e choice;
	owner_e cur_owner;
	logic   cpu_wait;
	logic   vid_wait;
	logic   cpu_stb_q;
	logic   vid_stb_q;

	// strobe lands on the next cbeg, so that request is already served
	assign cpu_wait = cpu_req.req && !cpu_stb_q;
	assign vid_wait = vid_req.req && !vid_stb_q;

	//////////////////////////////////////////////////
	// owner choice
	//////////////////////////////////////////////////

	always_comb
	begin
		// video first, but never twice in a row over a waiting cpu
		if (vid_wait && !(last_q == own_video && cpu_wait))
			choice = own_video;
		else if (cpu_wait)
			choice = own_cpu;
		else
			choice = own_none;
	end

	assign cur_owner = (phase == ph_cbeg) ? choice : owner_q;

	always_comb
	begin
		case (cur_owner)
			own_cpu:
				mem_req = cpu_req;
			own_video:
				mem_req = vid_req;
			default:
				mem_req = '0;
		endcase
	end

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			owner_q   <= own_none;
			last_q    <= own_none;
			cpu_stb_q <= 1'b0;
			vid_stb_q <= 1'b0;
		end
		else
		begin
			if (phase == ph_cbeg)
			begin
				owner_q <= choice;
				if (choice != own_none)
					last_q <= choice;
			end
			// one cycle after cend
			cpu_stb_q <= (phase == ph_cend) && (owner_q == own_cpu);
			vid_stb_q <= (phase == ph_cend) && (owner_q == own_video);
		end
	end

	//////////////////////////////////////////////////
	// return steering
	//////////////////////////////////////////////////

	assign cpu_rsp = '{strobe: cpu_stb_q, rdata: rd_data};
	assign vid_rsp = '{strobe: vid_stb_q, rdata: rd_data};

endmodule

`default_nettype wire

/* design/dram_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module dram_ctrl #(
	parameter int MEM_AW = 14
) (
	input  logic                     fclk,
	input  logic                     arst_n,
	input  zx_mem_pkg::dram_req_t    mem_req,
	output zx_mem_pkg::cycle_phase_e phase,
	output logic [15:0]              rd_data
);
	import zx_mem_pkg::*;

	cycle_phase_e      phase_q;
	cycle_phase_e      phase_nxt;
	logic [15:0]       mem [2**MEM_AW];
	logic [MEM_AW-1:0] idx;
	logic              do_cyc;

	assign phase  = phase_q;
	// only the low bits are decoded, higher pages alias
	assign idx    = mem_req.addr[MEM_AW-1:0];
	assign do_cyc = (phase_q == ph_cend) && mem_req.req;

	always_comb
	begin
		case (phase_q)
			ph_cbeg:
				phase_nxt = ph_post_cbeg;
			ph_post_cbeg:
				phase_nxt = ph_pre_cend;
			ph_pre_cend:
				phase_nxt = ph_cend;
			default:
				phase_nxt = ph_cbeg;
		endcase
	end

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			phase_q <= ph_cbeg;
		else
			phase_q <= phase_nxt;
	end

	//////////////////////////////////////////////////
	// word array
	//////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (do_cyc)
		begin
			if (mem_req.rnw)
				rd_data <= mem[idx];
			else
			begin
				// byte lanes
				if (mem_req.bsel[0])
					mem[idx][7:0] <= mem_req.wdata[7:0];
				if (mem_req.bsel[1])
					mem[idx][15:8] <= mem_req.wdata[15:8];
			end
		end
	end

endmodule

`default_nettype wire

/* design/mem_pager.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_pager (
	input  logic                            fclk,
	input  logic                            arst_n,
	input  zx_mem_pkg::cfg_wr_t             cfg_wr,
	input  logic [zx_mem_pkg::z_addr_w-1:0] z_addr,
	output zx_mem_pkg::map_t                map
);
	import zx_mem_pkg::*;

	page_t      page_q [4];
	logic [3:0] rom_q;
	logic [1:0] win;

	// top two address bits pick the 16 KB window
	assign win = z_addr[z_addr_w-1 -: 2];

	assign map = '{addr: {page_q[win], z_addr[13:1]}, is_rom: rom_q[win]};

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			// identity mapping, all ram
			for (int i = 0; i < 4; i++)
			begin
				page_q[i] <= page_t'(i);
			end
			rom_q <= 4'b0000;
		end
		else if (cfg_wr.valid)
		begin
			case (cfg_wr.sel)
				cfg_page0,
				cfg_page1,
				cfg_page2,
				cfg_page3:
					page_q[cfg_wr.sel[1:0]] <= cfg_wr.data;
				cfg_rom0,
				cfg_rom1,
				cfg_rom2,
				cfg_rom3:
					rom_q[cfg_wr.sel[1:0]] <= cfg_wr.data[0];
				default:
					;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/video_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module video_fetch #(
	parameter int FETCH_WORDS = 8
) (
	input  logic                  fclk,
	input  logic                  arst_n,
	input  zx_mem_pkg::cfg_wr_t   cfg_wr,
	input  logic                  line_start,
	input  zx_mem_pkg::dram_rsp_t vid_rsp,
	output zx_mem_pkg::dram_req_t vid_req,
	output logic [15:0]           pix_data,
	output logic                  pix_valid
);
	import zx_mem_pkg::*;

	localparam int cnt_w = $clog2(FETCH_WORDS + 1);
	localparam int off_w = word_addr_w - $bits(page_t);

	page_t            vbase_q;
	logic [cnt_w-1:0] cnt_q;
	logic             busy;

	// counter parks at FETCH_WORDS when idle
	assign busy = cnt_q < cnt_w'(FETCH_WORDS);

	assign vid_req = '{req: busy, addr: {vbase_q, off_w'(cnt_q)}, rnw: 1'b1,
		wdata: 16'h0000, bsel: 2'b11};

	// no back-pressure from the display
	assign pix_valid = vid_rsp.strobe;
	assign pix_data  = vid_rsp.rdata;

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			vbase_q <= '0;
			cnt_q   <= cnt_w'(FETCH_WORDS);
		end
		else
		begin
			if (cfg_wr.valid && cfg_wr.sel == cfg_vbase)
				vbase_q <= cfg_wr.data;
			if (vid_rsp.strobe)
				cnt_q <= cnt_q + 1'b1;
			else if (line_start && !busy)
				cnt_q <= '0;
		end
	end

endmodule

`default_nettype wire

/* design/zx_dram_arb_top.sv */
`timescale 1ns/100ps
`default_nettype none

module zx_dram_arb_top (
	input  logic                          fclk,
	input  logic                          arst_n,
	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  logic [zx_mem_pkg::z_addr_w:0] paddr,
	input  logic [7:0]                    pwdata,
	input  logic                          line_start,
	output logic [7:0]                    prdata,
	output logic                          pready,
	output logic [15:0]                   pix_data,
	output logic                          pix_valid
);
	import zx_mem_pkg::*;

	localparam int MEM_AW      = 14;
	localparam int FETCH_WORDS = 8;

	logic [z_addr_w-1:0] z_addr;
	map_t                map;
	cfg_wr_t             cfg_wr;
	dram_req_t           cpu_req;
	dram_req_t           vid_req;
	dram_req_t           mem_req;
	dram_rsp_t           cpu_rsp;
	dram_rsp_t           vid_rsp;
	cycle_phase_e        phase;
	logic [15:0]         rd_data;

	//////////////////////////////////////////////////
	// peers
	//////////////////////////////////////////////////

	apb_cpu_bridge u_bridge (
		.fclk(fclk), .arst_n(arst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .map(map), .cpu_rsp(cpu_rsp),
		.prdata(prdata), .pready(pready), .z_addr(z_addr),
		.cfg_wr(cfg_wr), .cpu_req(cpu_req)
	);

	mem_pager u_pager (
		.fclk(fclk), .arst_n(arst_n), .cfg_wr(cfg_wr), .z_addr(z_addr), .map(map)
	);

	video_fetch #(.FETCH_WORDS(FETCH_WORDS)) u_video (
		.fclk(fclk), .arst_n(arst_n), .cfg_wr(cfg_wr), .line_start(line_start),
		.vid_rsp(vid_rsp), .vid_req(vid_req), .pix_data(pix_data), .pix_valid(pix_valid)
	);

	// shared dram
	dram_arbiter u_arb (
		.fclk(fclk), .arst_n(arst_n), .phase(phase),
		.cpu_req(cpu_req), .vid_req(vid_req), .rd_data(rd_data),
		.mem_req(mem_req), .cpu_rsp(cpu_rsp), .vid_rsp(vid_rsp)
	);

	dram_ctrl #(.MEM_AW(MEM_AW)) u_dram (
		.fclk(fclk), .arst_n(arst_n), .mem_req(mem_req), .phase(phase), .rd_data(rd_data)
	);

endmodule

`default_nettype wire

/* design/zx_mem_pkg.sv */
`default_nettype none

package zx_mem_pkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////

	localparam int z_addr_w    = 16;
	// page followed by word offset within a 16 KB window
	localparam int word_addr_w = 21;

	typedef logic [7:0] page_t;

	//////////////////////////////////////////////////
	// enums
	//////////////////////////////////////////////////

	// four fclk phases of one dram cycle
	typedef enum logic [1:0] {ph_cbeg, ph_post_cbeg, ph_pre_cend, ph_cend} cycle_phase_e;

	typedef enum logic [1:0] {own_none, own_cpu, own_video} owner_e;

	typedef enum logic [3:0] {
		cfg_page0 = 4'd0,
		cfg_page1 = 4'd1,
		cfg_page2 = 4'd2,
		cfg_page3 = 4'd3,
		cfg_rom0  = 4'd4,
		cfg_rom1  = 4'd5,
		cfg_rom2  = 4'd6,
		cfg_rom3  = 4'd7,
		cfg_vbase = 4'd8
	} cfg_reg_e;

	//////////////////////////////////////////////////
	// structs
	//////////////////////////////////////////////////

	typedef struct packed {
		logic             valid;
		cfg_reg_e         sel;
		logic [7:0]       data;
	} cfg_wr_t;

	typedef struct packed {
		logic [word_addr_w-1:0] addr;
		logic                   is_rom;
	} map_t;

	typedef struct packed {
		logic                   req;
		logic [word_addr_w-1:0] addr;
		logic                   rnw;
		logic [15:0]            wdata;
		logic [1:0]             bsel;
	} dram_req_t;

	typedef struct packed {
		logic        strobe;
		logic [15:0] rdata;
	} dram_rsp_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_zx_dram_arb -f zx_dram_arb.f -o sim_tb \
	&& ./obj_dir/sim_tb 2>&1 | tee sim.log

grep -qs "^Simulation finished: PASS$" sim.log && echo "result: passed" \
	|| { echo "result: failed"; exit 1; }

/* testbench/tb_zx_dram_arb.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_zx_dram_arb;
	import zx_mem_pkg::*;

	localparam int fetch_words = 8;
	localparam int drive_dly   = 1;
	// tests take roughly 1000 cycles, about four times that
	localparam int max_cycles  = 4000;

	logic              fclk;
	logic              arst_n;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [z_addr_w:0] paddr;
	logic [7:0]        pwdata;
	logic              line_start;
	logic [7:0]        prdata;
	logic              pready;
	logic [15:0]       pix_data;
	logic              pix_valid;

	logic [31:0] rng_state;
	int          cycles = 0;
	int          n_tests;
	int          n_checks;
	int          n_errors;
	logic [15:0] pix_expect [fetch_words];

	zx_dram_arb_top i_dut (
		.fclk(fclk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .line_start(line_start), .prdata(prdata),
		.pready(pready), .pix_data(pix_data), .pix_valid(pix_valid)
	);

	initial
	begin
		fclk = 1'b0;
		forever
			#2 fclk = ~fclk;
	end

	always @(posedge fclk)
	begin
		cycles++;
		if (cycles >= max_cycles)
		begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	// lcg, upper bits give the data byte
	function automatic logic [7:0] next_byte();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state[23:16];
	endfunction

	function automatic logic [z_addr_w:0] mem_addr(input logic [z_addr_w-1:0] z);
		return {1'b0, z};
	endfunction

	function automatic logic [z_addr_w:0] cfg_addr(input cfg_reg_e sel);
		return {1'b1, 12'h000, sel};
	endfunction

	task automatic compare_byte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		n_checks++;
		if (actual !== expected)
		begin
			n_errors++;
			$display("[ERROR] %s: expected %02h, actual %02h", name, expected, actual);
		end
	endtask

	task automatic compare_word(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		n_checks++;
		if (actual !== expected)
		begin
			n_errors++;
			$display("[ERROR] %s: expected %04h, actual %04h", name, expected, actual);
		end
	endtask

	// entered 1 ns after a rising edge, leaves at the same point
	task automatic apb_transfer(input logic write, input logic [z_addr_w:0] addr,
		input logic [7:0] wdata, output logic [7:0] rdata);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge fclk);
		#drive_dly;
		penable = 1'b1;
		@(negedge fclk);
		while (!pready)
			@(negedge fclk);
		rdata = prdata;
		@(posedge fclk);
		#drive_dly;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [z_addr_w:0] addr, input logic [7:0] data);
		logic [7:0] unused;
		apb_transfer(1'b1, addr, data, unused);
	endtask

	task automatic apb_read(input logic [z_addr_w:0] addr, output logic [7:0] data);
		apb_transfer(1'b0, addr, 8'h00, data);
	endtask

	task automatic set_cfg(input cfg_reg_e sel, input logic [7:0] value);
		apb_write(cfg_addr(sel), value);
	endtask

	task automatic expect_read(input string name, input logic [z_addr_w:0] addr,
		input logic [7:0] expected);
		logic [7:0] rdata;
		apb_read(addr, rdata);
		compare_byte($sformatf("%s addr %05h", name, addr), expected, rdata);
	endtask

	task automatic report_test(input string name, input int errs_before);
		n_tests++;
		if (n_errors == errs_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, n_errors - errs_before);
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	task automatic test_reset();
		int errs;
		errs = n_errors;
		if (pready !== 1'b0 || pix_valid !== 1'b0)
		begin
			n_errors++;
			$display("pready or pix_valid is not low after reset");
		end
		// config registers read as unused ports
		expect_read("reset", cfg_addr(cfg_page0), 8'hff);
		expect_read("reset", cfg_addr(cfg_vbase), 8'hff);
		report_test("reset", errs);
	endtask

	task automatic test_byte_access();
		logic [z_addr_w-1:0] z;
		logic [7:0]          lo;
		logic [7:0]          hi;
		int                  errs;
		errs = n_errors;
		for (int w = 1; w < 4; w++)
		begin
			for (int k = 0; k < 2; k++)
			begin
				// windows 1 and 3 alias in the array, offsets differ per window
				z  = 16'(w * 16'h4000 + 16'h0100 + w * 16 + k * 2);
				lo = next_byte();
				hi = next_byte();
				apb_write(mem_addr(z), lo);
				apb_write(mem_addr(z + 16'd1), hi);
				expect_read("byte_access", mem_addr(z), lo);
				expect_read("byte_access", mem_addr(z + 16'd1), hi);
				// rewrite one lane, the other stays
				if (k == 0)
				begin
					lo = next_byte();
					apb_write(mem_addr(z), lo);
				end
				else
				begin
					hi = next_byte();
					apb_write(mem_addr(z + 16'd1), hi);
				end
				expect_read("byte_access", mem_addr(z), lo);
				expect_read("byte_access", mem_addr(z + 16'd1), hi);
			end
		end
		report_test("byte_access", errs);
	endtask

	task automatic test_paging();
		logic [7:0] b1;
		logic [7:0] b3;
		int         errs;
		errs = n_errors;
		b1 = next_byte();
		b3 = ~b1;
		// page 4 has a different low bit than page 3
		set_cfg(cfg_page1, 8'h04);
		apb_write(mem_addr(16'hc200), b3);
		apb_write(mem_addr(16'h4200), b1);
		set_cfg(cfg_page3, 8'h04);
		expect_read("paging", mem_addr(16'hc200), b1);
		expect_read("paging", mem_addr(16'h4200), b1);
		set_cfg(cfg_page1, 8'h01);
		set_cfg(cfg_page3, 8'h03);
		expect_read("paging", mem_addr(16'hc200), b3);
		report_test("paging", errs);
	endtask

	task automatic test_rom_flag();
		logic [7:0] old_b;
		logic [7:0] new_b;
		int         errs;
		errs  = n_errors;
		old_b = next_byte();
		new_b = ~old_b;
		apb_write(mem_addr(16'h8300), old_b);
		set_cfg(cfg_rom2, 8'h01);
		apb_write(mem_addr(16'h8300), new_b);
		expect_read("rom_flag", mem_addr(16'h8300), old_b);
		set_cfg(cfg_rom2, 8'h00);
		apb_write(mem_addr(16'h8300), new_b);
		expect_read("rom_flag", mem_addr(16'h8300), new_b);
		report_test("rom_flag", errs);
	endtask

	task automatic test_video_arb();
		logic [7:0] b;
		logic       reads_done;
		int         seen;
		int         errs;
		errs       = n_errors;
		seen       = 0;
		reads_done = 1'b0;
		set_cfg(cfg_vbase, 8'h06);
		// window 0 onto the video page
		set_cfg(cfg_page0, 8'h06);
		for (int k = 0; k < fetch_words; k++)
		begin
			pix_expect[k] = {next_byte(), next_byte()};
			apb_write(mem_addr(16'(2 * k)), pix_expect[k][7:0]);
			apb_write(mem_addr(16'(2 * k + 1)), pix_expect[k][15:8]);
		end
		fork
			begin
				line_start = 1'b1;
				@(posedge fclk);
				#drive_dly;
				line_start = 1'b0;
				// second pulse lands mid-fetch
				repeat (6) @(posedge fclk);
				#drive_dly;
				line_start = 1'b1;
				@(posedge fclk);
				#drive_dly;
				line_start = 1'b0;
			end
			begin
				for (int i = 0; i < 2 * fetch_words; i++)
					expect_read("video_arb", mem_addr(16'(i)),
						i[0] ? pix_expect[i / 2][15:8] : pix_expect[i / 2][7:0]);
				for (int k = 0; k < 4; k++)
				begin
					b = next_byte();
					apb_write(mem_addr(16'h4400 + 16'(k)), b);
					expect_read("video_arb", mem_addr(16'h4400 + 16'(k)), b);
				end
				reads_done = 1'b1;
			end
			begin
				// every pulse is counted, the first line is checked in order
				while (!reads_done)
				begin
					@(negedge fclk);
					if (pix_valid)
					begin
						if (seen < fetch_words)
							compare_word($sformatf("video_arb pixel %0d", seen),
								pix_expect[seen], pix_data);
						seen++;
					end
				end
			end
		join
		// no further pixels once the line is done
		repeat (16)
		begin
			@(negedge fclk);
			if (pix_valid)
				seen++;
		end
		if (seen != fetch_words)
		begin
			n_errors++;
			$display("[ERROR] video_arb pixel count: expected %0d, actual %0d",
				fetch_words, seen);
		end
		report_test("video_arb", errs);
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial
	begin
		arst_n     = 1'b0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = 8'h00;
		line_start = 1'b0;
		rng_state  = 32'hbcddebff;
		n_tests    = 0;
		n_checks   = 0;
		n_errors   = 0;
		repeat (3) @(posedge fclk);
		#drive_dly;
		arst_n = 1'b1;
		test_reset();
		test_byte_access();
		test_paging();
		test_rom_flag();
		test_video_arb();
		$display("tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/zx_dram_arb_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module zx_dram_arb_asserts (
	input logic                     fclk,
	input logic                     arst_n,
	input logic                     psel,
	input logic                     penable,
	input logic                     pready,
	input zx_mem_pkg::cycle_phase_e phase,
	input zx_mem_pkg::owner_e       owner,
	input logic                     cpu_stb,
	input logic                     vid_stb
);
	import zx_mem_pkg::*;

	// apb completion only inside an access phase
	pready_in_access: assert property (@(posedge fclk) disable iff (!arst_n)
		pready |-> (psel && penable))
		else $error("pready high outside an apb access phase");

	// one owner per dram cycle
	strobe_exclusive: assert property (@(posedge fclk) disable iff (!arst_n)
		!(cpu_stb && vid_stb))
		else $error("cpu and video strobes high together");

	// owner won at cbeg gets its strobe right after that cycle's cend
	strobe_after_cend: assert property (@(posedge fclk) disable iff (!arst_n)
		($past(phase) == ph_cend && $past(phase, 4) == ph_cbeg)
			? (cpu_stb == ($past(owner, 4) == own_cpu)
				&& vid_stb == ($past(owner, 4) == own_video))
			: !(cpu_stb || vid_stb))
		else $error("response strobe does not follow the owned cycle's cend");

endmodule

// apb side, dram inputs tied off
bind apb_cpu_bridge zx_dram_arb_asserts u_apb_asserts (
	.fclk(fclk), .arst_n(arst_n), .psel(psel), .penable(penable), .pready(pready),
	.phase(zx_mem_pkg::ph_cbeg), .owner(zx_mem_pkg::own_none),
	.cpu_stb(1'b0), .vid_stb(1'b0)
);

// arbiter side, apb inputs tied off
bind dram_arbiter zx_dram_arb_asserts u_arb_asserts (
	.fclk(fclk), .arst_n(arst_n), .psel(1'b0), .penable(1'b0), .pready(1'b0),
	.phase(phase), .owner(cur_owner), .cpu_stb(cpu_stb_q), .vid_stb(vid_stb_q)
);

`default_nettype wire

/* zx_dram_arb.f */
design/zx_mem_pkg.sv
design/apb_cpu_bridge.sv
design/mem_pager.sv
design/dram_arbiter.sv
design/dram_ctrl.sv
design/video_fetch.sv
design/zx_dram_arb_top.sv
testbench/zx_dram_arb_asserts.sv
testbench/tb_zx_dram_arb.sv
